// File: common/uart_pkg.sv
// UART shared definitions
// Widths, reset values and register offsets
// Parity modes, FSM encodings, config and stream structs
// Parity helper used by both serial blocks

package uart_pkg;

    localparam int DATA_WIDTH     = 8;
    localparam int DIVIDER_WIDTH  = 16;
    localparam int FIFO_DEPTH     = 8;
    localparam int WB_DATA_WIDTH  = 32;
    localparam int BIT_CNT_WIDTH  = $clog2(DATA_WIDTH);
    localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    localparam logic [DIVIDER_WIDTH-1:0] DEFAULT_DIVIDER = 16'd16;

    // Word offsets on the Wishbone address
    localparam logic [1:0] REG_CTRL   = 2'd0;
    localparam logic [1:0] REG_STATUS = 2'd1;
    localparam logic [1:0] REG_TXDATA = 2'd2;
    localparam logic [1:0] REG_RXDATA = 2'd3;

    typedef enum logic [1:0] {
        PARITY_NONE = 2'b00,
        PARITY_EVEN = 2'b01,
        PARITY_ODD  = 2'b10
    } parity_mode_e;

    typedef enum logic [2:0] {
        RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP, RX_WAIT
    } rx_state_e;

    typedef enum logic [2:0] {
        TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP, TX_WAIT
    } tx_state_e;

    // Matches CTRL layout, parity in 17:16
    typedef struct packed {
        parity_mode_e             parity;
        logic [DIVIDER_WIDTH-1:0] divider;
    } uart_cfg_t;

    typedef struct packed {
        logic                  valid;
        logic [DATA_WIDTH-1:0] data;
    } byte_stream_t;

    function automatic logic parity_of(input logic [DATA_WIDTH-1:0] data,
                                       input parity_mode_e          mode);
        logic par;
        case (mode)
            PARITY_EVEN: par = ^data;
            PARITY_ODD:  par = ~^data;
            default:     par = 1'b0;
        endcase
        return par;
    endfunction

endpackage

// File: hdl/uart_fifo.sv
// Receive FIFO between the receiver and the register block
// Circular buffer with read/write pointers and a fill count
// Always ready on input, bytes arriving when full are dropped
`timescale 1ns/1ps

module uart_fifo
    import uart_pkg::*;
(
    input  logic         clk_i,
    input  logic         arstn_i,
    input  byte_stream_t wr_i,
    output logic         wr_ready_o,
    output byte_stream_t rd_o,
    input  logic         rd_ready_i,
    output logic         overrun_o
);

logic [DATA_WIDTH-1:0]     mem [FIFO_DEPTH];
logic [FIFO_PTR_WIDTH-1:0] wr_ptr;
logic [FIFO_PTR_WIDTH-1:0] rd_ptr;
logic [FIFO_CNT_WIDTH-1:0] count;
logic                      full;
logic                      push;
logic                      pop;

assign full = (count == FIFO_CNT_WIDTH'(FIFO_DEPTH));
assign pop  = rd_o.valid & rd_ready_i;
assign push = wr_i.valid & (~full | pop); // Slot freed by a pop in the same cycle

always_ff @(posedge clk_i or negedge arstn_i) begin
    if (~arstn_i) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end else begin
        if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
        if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
        case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
        endcase
    end
end

always_ff @(posedge clk_i) begin
    if (push) begin
        mem[wr_ptr] <= wr_i.data;
    end
end

assign wr_ready_o = 1'b1;
assign rd_o       = '{valid: (count != '0), data: mem[rd_ptr]};
assign overrun_o  = wr_i.valid & full & ~pop;

endmodule

// File: hdl/uart_top.sv
// UART top level
// Wishbone register block, receive FIFO, receiver and transmitter
`timescale 1ns/1ps

module uart_top
    import uart_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     arstn_i,

    input  logic                     wb_cyc_i,
    input  logic                     wb_stb_i,
    input  logic                     wb_we_i,
    input  logic [1:0]               wb_adr_i,
    input  logic [WB_DATA_WIDTH-1:0] wb_dat_i,
    output logic [WB_DATA_WIDTH-1:0] wb_dat_o,
    output logic                     wb_ack_o,

    input  logic                     uart_rx_i,
    output logic                     uart_tx_o
);

uart_cfg_t    cfg;
byte_stream_t tx_stream;
byte_stream_t rx_stream;
byte_stream_t fifo_stream;
logic         tx_ready;
logic         tx_busy;
logic         rx_ready;
logic         fifo_ready;
logic         parity_err;
logic         overrun;

uart_wb_regs uart_wb_regs_inst (
    .clk_i        (clk_i),
    .arstn_i      (arstn_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .cfg_o        (cfg),
    .tx_o         (tx_stream),
    .tx_ready_i   (tx_ready),
    .tx_busy_i    (tx_busy),
    .rx_i         (fifo_stream),
    .rx_ready_o   (fifo_ready),
    .parity_err_i (parity_err),
    .overrun_i    (overrun)
);

uart_fifo uart_fifo_inst (
    .clk_i      (clk_i),
    .arstn_i    (arstn_i),
    .wr_i       (rx_stream),
    .wr_ready_o (rx_ready),
    .rd_o       (fifo_stream),
    .rd_ready_i (fifo_ready),
    .overrun_o  (overrun)
);

uart_rx uart_rx_inst (
    .clk_i        (clk_i),
    .arstn_i      (arstn_i),
    .cfg_i        (cfg),
    .uart_rx_i    (uart_rx_i),
    .rx_o         (rx_stream),
    .rx_ready_i   (rx_ready),
    .parity_err_o (parity_err)
);

uart_tx uart_tx_inst (
    .clk_i      (clk_i),
    .arstn_i    (arstn_i),
    .cfg_i      (cfg),
    .tx_i       (tx_stream),
    .tx_ready_o (tx_ready),
    .uart_tx_o  (uart_tx_o),
    .busy_o     (tx_busy)
);

endmodule

// File: hdl/uart_wb_regs.sv
// Wishbone classic slave register block
// CTRL holds divider and parity mode
// STATUS with sticky parity error and overrun, cleared on read
// TXDATA write stalls ack until the transmitter takes the byte
// RXDATA read pops one byte from the receive FIFO
`timescale 1ns/1ps

module uart_wb_regs
    import uart_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     arstn_i,

    input  logic                     wb_cyc_i,
    input  logic                     wb_stb_i,
    input  logic                     wb_we_i,
    input  logic [1:0]               wb_adr_i,
    input  logic [WB_DATA_WIDTH-1:0] wb_dat_i,
    output logic [WB_DATA_WIDTH-1:0] wb_dat_o,
    output logic                     wb_ack_o,

    output uart_cfg_t                cfg_o,
    output byte_stream_t             tx_o,
    input  logic                     tx_ready_i,
    input  logic                     tx_busy_i,

    input  byte_stream_t             rx_i,
    output logic                     rx_ready_o,

    input  logic                     parity_err_i,
    input  logic                     overrun_i
);

uart_cfg_t                cfg_q;
logic [WB_DATA_WIDTH-1:0] rdata_q;
logic                     ack_q;
logic                     parity_err_q;
logic                     overrun_q;
logic                     req;
logic                     tx_wr;
logic                     rd_req;
logic                     status_rd;

assign req       = wb_cyc_i & wb_stb_i & ~ack_q; // Blocked during ack
assign tx_wr     = req & wb_we_i & (wb_adr_i == REG_TXDATA);
assign rd_req    = req & ~wb_we_i;
assign status_rd = rd_req & (wb_adr_i == REG_STATUS);

always_ff @(posedge clk_i or negedge arstn_i) begin
    if (~arstn_i) begin
        ack_q <= 1'b0;
    end else if (tx_wr) begin
        ack_q <= tx_ready_i;
    end else begin
        ack_q <= req;
    end
end

always_ff @(posedge clk_i or negedge arstn_i) begin
    if (~arstn_i) begin
        cfg_q <= '{parity: PARITY_NONE, divider: DEFAULT_DIVIDER};
    end else if (req && wb_we_i && (wb_adr_i == REG_CTRL)) begin
        cfg_q <= uart_cfg_t'(wb_dat_i[$bits(uart_cfg_t)-1:0]);
    end
end

// New events win over a clearing read
always_ff @(posedge clk_i or negedge arstn_i) begin
    if (~arstn_i) begin
        parity_err_q <= 1'b0;
        overrun_q    <= 1'b0;
    end else begin
        parity_err_q <= (parity_err_q & ~status_rd) | parity_err_i;
        overrun_q    <= (overrun_q & ~status_rd) | overrun_i;
    end
end

always_ff @(posedge clk_i) begin
    if (rd_req) begin
        case (wb_adr_i)
            REG_CTRL:   rdata_q <= WB_DATA_WIDTH'(cfg_q);
            REG_STATUS: rdata_q <= WB_DATA_WIDTH'({overrun_q, parity_err_q,
                                                   tx_busy_i, rx_i.valid});
            REG_RXDATA: rdata_q <= rx_i.valid ? WB_DATA_WIDTH'(rx_i.data) : '0;
            default:    rdata_q <= '0;
        endcase
    end
end

assign wb_ack_o   = ack_q;
assign wb_dat_o   = rdata_q;
assign cfg_o      = cfg_q;
assign tx_o       = '{valid: tx_wr, data: wb_dat_i[DATA_WIDTH-1:0]};
assign rx_ready_o = rd_req & (wb_adr_i == REG_RXDATA); // No pop when empty

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the UART testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module uart_tb -f uart_top.f \
    && ./obj_dir/Vuart_tb > sim.log 2>&1 \
    || echo "Build or simulation run did not complete"

cat sim.log 2>/dev/null
grep -qx "all tests passed" sim.log && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }

// File: testbench/uart_tb.sv
// Testbench for the UART top level
// Wishbone access task, serial line driver and frame monitor
// Receive line muxed between loopback and the driver
// Table of operations with expected bytes and status, applied in a loop
`timescale 1ns/1ps

module uart_tb
    import uart_pkg::*;
();

localparam int          TIMEOUT_MARGIN = 2000;
localparam int unsigned SEED           = 32'h112703c9;

typedef enum logic [2:0] {
    OP_RESET, OP_LOOP, OP_INJECT, OP_OVERRUN, OP_B2B
} op_e;

typedef struct packed {
    op_e                      op;
    logic [7:0]               data;
    parity_mode_e             parity;
    logic [DIVIDER_WIDTH-1:0] divider;
    logic                     inject;     // Flip the parity bit
    logic [7:0]               exp_data;
    logic [3:0]               exp_status;
} test_row_t;

logic        clk;
logic        arstn;
logic        wb_cyc;
logic        wb_stb;
logic        wb_we;
logic [1:0]  wb_adr;
logic [31:0] wb_dat_w;
logic [31:0] wb_dat_r;
logic        wb_ack;
logic        uart_rx;
logic        uart_tx;
logic        loopback;
logic        drv_line;
test_row_t   rows[$];
int          errors = 0;
int          cycle_cnt = 0;
int          cycle_limit = 0;
int          last_ack_cycle;

assign uart_rx = loopback ? uart_tx : drv_line;

uart_top uart_top_inst (
    .clk_i     (clk),
    .arstn_i   (arstn),
    .wb_cyc_i  (wb_cyc),
    .wb_stb_i  (wb_stb),
    .wb_we_i   (wb_we),
    .wb_adr_i  (wb_adr),
    .wb_dat_i  (wb_dat_w),
    .wb_dat_o  (wb_dat_r),
    .wb_ack_o  (wb_ack),
    .uart_rx_i (uart_rx),
    .uart_tx_o (uart_tx)
);

initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
end

always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if ((cycle_limit > 0) && (cycle_cnt > cycle_limit)) begin
        $display("Timeout after %0d cycles, run stopped", cycle_cnt);
        $display("tests failed");
        $finish;
    end
end

// Even parity makes the count of ones even, odd makes it odd
function automatic logic calc_parity(input logic [7:0] data, input parity_mode_e mode);
    int ones;
    int i;
    ones = 0;
    for (i = 0; i < 8; i++) begin
        ones += int'(data[i]);
    end
    if (mode == PARITY_ODD) begin
        return (ones % 2) == 0;
    end
    return (ones % 2) == 1;
endfunction

function automatic int frame_bits(input parity_mode_e mode);
    return (mode == PARITY_NONE) ? 10 : 11;
endfunction

function automatic int run_length();
    int total;
    int frames;
    total = 0;
    foreach (rows[i]) begin
        case (rows[i].op)
            OP_LOOP, OP_INJECT: frames = 1;
            OP_OVERRUN:         frames = FIFO_DEPTH + 1;
            OP_B2B:             frames = 2;
            default:            frames = 0;
        endcase
        total += frames * frame_bits(rows[i].parity) * int'(rows[i].divider);
    end
    return total + TIMEOUT_MARGIN;
endfunction

task automatic report_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    $display("[FAIL] %s: expected 0x%h, got 0x%h", name, exp, got);
    errors++;
endtask

task automatic add_row(input op_e op, input logic [7:0] data, input parity_mode_e par,
                       input logic [15:0] div, input logic inject,
                       input logic [7:0] exp_data, input logic [3:0] exp_status);
    test_row_t row;
    row.op         = op;
    row.data       = data;
    row.parity     = par;
    row.divider    = div;
    row.inject     = inject;
    row.exp_data   = exp_data;
    row.exp_status = exp_status;
    rows.push_back(row);
endtask

task automatic load_table();
    logic [7:0] b;
    int i;
    add_row(OP_RESET, 8'h00, PARITY_NONE, 16'd16, 1'b0, 8'h00, 4'h0);
    for (i = 0; i < 4; i++) begin
        b = 8'($urandom);
        add_row(OP_LOOP, b, PARITY_NONE, (i < 2) ? 16'd16 : 16'd8, 1'b0, b, 4'h0);
    end
    for (i = 0; i < 4; i++) begin
        b = 8'($urandom);
        add_row(OP_LOOP, b, (i % 2 == 0) ? PARITY_EVEN : PARITY_ODD,
                (i < 2) ? 16'd16 : 16'd8, 1'b0, b, 4'h0);
    end
    add_row(OP_INJECT, 8'h5a, PARITY_EVEN, 16'd16, 1'b1, 8'h00, 4'h4);
    add_row(OP_INJECT, 8'h3c, PARITY_ODD, 16'd8, 1'b1, 8'h00, 4'h4);
    add_row(OP_OVERRUN, 8'h00, PARITY_NONE, 16'd8, 1'b0, 8'h00, 4'h9); // rx_not_empty and overrun
    b = 8'($urandom);
    add_row(OP_B2B, b, PARITY_NONE, 16'd8, 1'b0, b, 4'h0);
endtask

task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] wdata,
                         output logic [31:0] rdata);
    int waits;
    waits = 0;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdata;
    do begin
        @(negedge clk);
        waits++;
    end while (wb_ack !== 1'b1);
    rdata          = wb_dat_r;
    last_ack_cycle = cycle_cnt;
    // Only a TXDATA write may stretch the cycle
    if ((waits != 2) && !(we && (adr == REG_TXDATA))) begin
        $display("wb_ack_o did not come in the cycle after the strobe");
        errors++;
    end
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    @(negedge clk);
    if (wb_ack !== 1'b0) begin
        $display("wb_ack_o stayed high for more than one cycle");
        errors++;
    end
endtask

task automatic read_and_check(input logic [1:0] adr, input logic [31:0] exp,
                              input string name);
    logic [31:0] rdata;
    wb_access(1'b0, adr, 32'h0, rdata);
    if (rdata !== exp) report_mismatch(name, rdata, exp);
endtask

task automatic set_config(input parity_mode_e par, input logic [15:0] div);
    logic [31:0] rdata;
    wb_access(1'b1, REG_CTRL, {14'b0, par, div}, rdata);
endtask

// Samples uart_tx_o mid-bit and returns after the stop bit ends
task automatic capture_frame(input int div, input logic par_en,
                             output logic [7:0] data, output logic par);
    int wait_cnt;
    int i;
    wait_cnt = 0;
    data     = '0;
    par      = 1'b0;
    do begin
        @(negedge clk);
        wait_cnt++;
        if (wait_cnt > 20 * div) begin
            $display("No start bit seen on uart_tx_o");
            errors++;
            return;
        end
    end while (uart_tx !== 1'b0);
    repeat (div / 2) @(negedge clk);
    for (i = 0; i < 8; i++) begin
        repeat (div) @(negedge clk);
        data[i] = uart_tx;
    end
    if (par_en) begin
        repeat (div) @(negedge clk);
        par = uart_tx;
    end
    repeat (div) @(negedge clk);
    if (uart_tx !== 1'b1) report_mismatch("uart_tx_o stop bit", {31'b0, uart_tx}, 32'h1);
    repeat (div / 2) @(negedge clk);
endtask

task automatic drive_frame(input logic [7:0] data, input parity_mode_e mode,
                           input int div, input logic flip);
    logic [10:0] bits;
    int nbits;
    int i;
    if (mode == PARITY_NONE) begin
        bits  = {2'b11, data, 1'b0};
        nbits = 10;
    end else begin
        bits  = {1'b1, calc_parity(data, mode) ^ flip, data, 1'b0};
        nbits = 11;
    end
    for (i = 0; i < nbits; i++) begin
        @(posedge clk);
        drv_line <= bits[i];
        repeat (div - 1) @(posedge clk);
    end
endtask

task automatic send_and_check(input logic [7:0] data, input parity_mode_e par, input int div);
    logic [31:0] rdata;
    logic [31:0] status;
    logic [7:0]  got;
    logic        got_par;
    fork
        begin
            wb_access(1'b1, REG_TXDATA, 32'(data), rdata);
            wb_access(1'b0, REG_STATUS, 32'h0, status); // Frame still on the line
            if (status[1] !== 1'b1) begin
                report_mismatch("wb_dat_o STATUS tx_busy", {31'b0, status[1]}, 32'h1);
            end
        end
        capture_frame(div, par != PARITY_NONE, got, got_par);
    join
    if (got !== data) report_mismatch("uart_tx_o data", 32'(got), 32'(data));
    if ((par != PARITY_NONE) && (got_par !== calc_parity(data, par))) begin
        report_mismatch("uart_tx_o parity", {31'b0, got_par}, {31'b0, calc_parity(data, par)});
    end
endtask

task automatic wait_rx_byte();
    logic [31:0] status;
    int tries;
    tries = 0;
    do begin
        wb_access(1'b0, REG_STATUS, 32'h0, status);
        tries++;
    end while ((status[0] !== 1'b1) && (tries < 16));
    if (status[0] !== 1'b1) begin
        $display("No received byte reached the receive FIFO");
        errors++;
    end
endtask

task automatic run_row(input test_row_t row);
    logic [7:0]  sent[$];
    logic [7:0]  b;
    logic [7:0]  a_got;
    logic [7:0]  b_got;
    logic [31:0] rdata;
    logic        par_got;
    int          div;
    int          t_a;
    int          t_b;
    int          i;
    div = int'(row.divider);
    if (row.op != OP_RESET) set_config(row.parity, row.divider);
    case (row.op)
        OP_RESET: begin
            read_and_check(REG_STATUS, 32'(row.exp_status), "wb_dat_o STATUS");
            read_and_check(REG_CTRL, 32'h0000_0010, "wb_dat_o CTRL"); // Divider 16, no parity
            read_and_check(REG_RXDATA, 32'(row.exp_data), "wb_dat_o RXDATA");
            if (uart_tx !== 1'b1) report_mismatch("uart_tx_o", {31'b0, uart_tx}, 32'h1);
        end
        OP_LOOP: begin
            send_and_check(row.data, row.parity, div);
            wait_rx_byte();
            read_and_check(REG_RXDATA, 32'(row.exp_data), "wb_dat_o RXDATA");
            read_and_check(REG_STATUS, 32'(row.exp_status), "wb_dat_o STATUS");
        end
        OP_INJECT: begin
            @(posedge clk);
            loopback <= 1'b0;
            drive_frame(row.data, row.parity, div, row.inject);
            read_and_check(REG_STATUS, 32'(row.exp_status), "wb_dat_o STATUS");
            read_and_check(REG_STATUS, 32'h0, "wb_dat_o STATUS second read");
            read_and_check(REG_RXDATA, 32'(row.exp_data), "wb_dat_o RXDATA");
            @(posedge clk);
            loopback <= 1'b1;
        end
        OP_OVERRUN: begin
            repeat (FIFO_DEPTH + 1) begin
                b = 8'($urandom);
                sent.push_back(b);
                send_and_check(b, row.parity, div);
            end
            read_and_check(REG_STATUS, 32'(row.exp_status), "wb_dat_o STATUS");
            for (i = 0; i < FIFO_DEPTH; i++) begin
                read_and_check(REG_RXDATA, 32'(sent[i]), "wb_dat_o RXDATA");
            end
            read_and_check(REG_STATUS, 32'h0, "wb_dat_o STATUS after drain"); // Ninth byte lost
        end
        OP_B2B: begin
            b = row.data ^ 8'hff;
            fork
                begin
                    wb_access(1'b1, REG_TXDATA, 32'(row.data), rdata);
                    t_a = last_ack_cycle;
                    wb_access(1'b1, REG_TXDATA, 32'(b), rdata);
                    t_b = last_ack_cycle;
                end
                begin
                    capture_frame(div, 1'b0, a_got, par_got);
                    capture_frame(div, 1'b0, b_got, par_got);
                end
            join
            if (t_b - t_a < frame_bits(row.parity) * div) begin
                $display("Second TXDATA ack came %0d cycles after the first, inside the frame",
                         t_b - t_a);
                errors++;
            end
            if (a_got !== row.data) report_mismatch("uart_tx_o data", 32'(a_got), 32'(row.data));
            if (b_got !== b) report_mismatch("uart_tx_o data", 32'(b_got), 32'(b));
            read_and_check(REG_RXDATA, 32'(row.exp_data), "wb_dat_o RXDATA first");
            read_and_check(REG_RXDATA, 32'(b), "wb_dat_o RXDATA second");
        end
        default: begin
            $display("Unknown operation in table row");
            errors++;
        end
    endcase
endtask

initial begin
    int          errors_before;
    int          passed;
    op_e         op;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = 2'd0;
    wb_dat_w = 32'h0;
    drv_line = 1'b1;
    loopback = 1'b1;
    arstn    = 1'b0;
    passed   = 0;
    void'($urandom(SEED));
    load_table();
    cycle_limit = run_length();
    repeat (3) @(posedge clk);
    arstn <= 1'b1;
    foreach (rows[i]) begin
        errors_before = errors;
        op            = rows[i].op;
        run_row(rows[i]);
        if (errors == errors_before) begin
            passed++;
            $display("test %0d %s data 0x%h: passed", i, op.name(), rows[i].data);
        end else begin
            $display("test %0d %s data 0x%h: failed", i, op.name(), rows[i].data);
        end
    end
    $display("%0d of %0d table rows passed, %0d check errors", passed, rows.size(), errors);
    if (errors == 0) begin
        $display("all tests passed");
    end else begin
        $display("tests failed");
    end
    $finish;
end

endmodule

// File: uart_rx/uart_rx.sv
// Serial receiver
// Start bit qualified at half a bit period
// Data sampled mid-bit, LSB first
// Optional parity check with bad frames dropped
// Good frames leave on a valid/ready byte stream
`timescale 1ns/1ps

module uart_rx
    import uart_pkg::*;
(
    input  logic         clk_i,
    input  logic         arstn_i,
    input  uart_cfg_t    cfg_i,
    input  logic         uart_rx_i,
    output byte_stream_t rx_o,
    input  logic         rx_ready_i,
    output logic         parity_err_o
);

rx_state_e                state;
logic [DIVIDER_WIDTH-1:0] baud_cnt;
logic [BIT_CNT_WIDTH-1:0] bit_cnt;
logic [DATA_WIDTH-1:0]    rx_data;
logic [DATA_WIDTH-1:0]    data_q;
logic                     valid_q;
logic                     frame_err;
logic                     baud_done;
logic                     start_check;
logic                     last_bit;

assign baud_done   = (baud_cnt == cfg_i.divider - 1'b1);
assign start_check = (state == RX_START) && (baud_cnt == (cfg_i.divider >> 1) - 1'b1);
assign last_bit    = (bit_cnt == BIT_CNT_WIDTH'(DATA_WIDTH - 1));

always_ff @(posedge clk_i or negedge arstn_i) begin
    if (~arstn_i) begin
        state     <= RX_IDLE;
        bit_cnt   <= '0;
        frame_err <= 1'b0;
    end else begin
        case (state)
            RX_IDLE: begin
                bit_cnt   <= '0;
                frame_err <= 1'b0;
                if (~uart_rx_i) begin
                    state <= RX_START;
                end
            end
            RX_START: begin
                if (start_check) begin
                    state <= uart_rx_i ? RX_IDLE : RX_DATA; // Glitch goes back to idle
                end
            end
            RX_DATA: begin
                if (baud_done) begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (last_bit) begin
                        state <= (cfg_i.parity == PARITY_NONE) ? RX_STOP : RX_PARITY;
                    end
                end
            end
            RX_PARITY: begin
                if (baud_done) begin
                    frame_err <= (uart_rx_i != parity_of(rx_data, cfg_i.parity));
                    state     <= RX_STOP;
                end
            end
            RX_STOP: begin
                if (baud_done) begin
                    state <= RX_WAIT; // Leave mid stop bit
                end
            end
            RX_WAIT: state <= RX_IDLE;
            default: state <= RX_IDLE;
        endcase
    end
end

// Restarts at mid start bit so later bits are hit in the middle
always_ff @(posedge clk_i or negedge arstn_i) begin
    if (~arstn_i) begin
        baud_cnt <= '0;
    end else if ((state == RX_IDLE) || start_check || baud_done) begin
        baud_cnt <= '0;
    end else begin
        baud_cnt <= baud_cnt + 1'b1;
    end
end

always_ff @(posedge clk_i) begin
    if ((state == RX_DATA) && baud_done) begin
        rx_data[bit_cnt] <= uart_rx_i;
    end
end

always_ff @(posedge clk_i or negedge arstn_i) begin
    if (~arstn_i) begin
        valid_q <= 1'b0;
    end else if (valid_q && rx_ready_i) begin
        valid_q <= 1'b0;
    end else if ((state == RX_WAIT) && ~frame_err) begin
        valid_q <= 1'b1;
    end
end

always_ff @(posedge clk_i) begin
    if ((state == RX_WAIT) && ~frame_err) begin
        data_q <= rx_data;
    end
end

assign rx_o         = '{valid: valid_q, data: data_q};
assign parity_err_o = (state == RX_WAIT) && frame_err;

endmodule

// File: uart_top.f
common/uart_pkg.sv
uart_rx/uart_rx.sv
uart_tx/uart_tx.sv
hdl/uart_fifo.sv
hdl/uart_wb_regs.sv
hdl/uart_top.sv
testbench/uart_tb.sv

// File: uart_tx/uart_tx.sv
// Serial transmitter
// Accepts a stream byte in idle only
// Sends start, 8 data bits LSB first, optional parity and one stop bit
`timescale 1ns/1ps

module uart_tx
    import uart_pkg::*;
(
    input  logic         clk_i,
    input  logic         arstn_i,
    input  uart_cfg_t    cfg_i,
    input  byte_stream_t tx_i,
    output logic         tx_ready_o,
    output logic         uart_tx_o,
    output logic         busy_o
);

tx_state_e                state;
logic [DIVIDER_WIDTH-1:0] baud_cnt;
logic [BIT_CNT_WIDTH-1:0] bit_cnt;
logic [DATA_WIDTH-1:0]    shift_q;
logic                     par_bit;
logic                     par_en;
logic                     line_q;
logic                     baud_done;
logic                     tx_handshake;

assign baud_done    = (baud_cnt == cfg_i.divider - 1'b1);
assign tx_ready_o   = (state == TX_IDLE);
assign tx_handshake = tx_i.valid & tx_ready_o;

always_ff @(posedge clk_i or negedge arstn_i) begin
    if (~arstn_i) begin
        state   <= TX_IDLE;
        bit_cnt <= '0;
        line_q  <= 1'b1;
    end else begin
        case (state)
            TX_IDLE: begin
                bit_cnt <= '0;
                if (tx_i.valid) begin
                    line_q <= 1'b0; // Start bit
                    state  <= TX_START;
                end
            end
            TX_START: begin
                if (baud_done) begin
                    line_q <= shift_q[0];
                    state  <= TX_DATA;
                end
            end
            TX_DATA: begin
                if (baud_done) begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == BIT_CNT_WIDTH'(DATA_WIDTH - 1)) begin
                        line_q <= par_en ? par_bit : 1'b1;
                        state  <= par_en ? TX_PARITY : TX_STOP;
                    end else begin
                        line_q <= shift_q[1];
                    end
                end
            end
            TX_PARITY: begin
                if (baud_done) begin
                    line_q <= 1'b1;
                    state  <= TX_STOP;
                end
            end
            TX_STOP: begin
                if (baud_done) begin
                    state <= TX_WAIT;
                end
            end
            TX_WAIT: state <= TX_IDLE; // One idle cycle between frames
            default: state <= TX_IDLE;
        endcase
    end
end

always_ff @(posedge clk_i or negedge arstn_i) begin
    if (~arstn_i) begin
        baud_cnt <= '0;
    end else if ((state == TX_IDLE) || (state == TX_WAIT) || baud_done) begin
        baud_cnt <= '0;
    end else begin
        baud_cnt <= baud_cnt + 1'b1;
    end
end

// Byte and parity frozen at acceptance
always_ff @(posedge clk_i) begin
    if (tx_handshake) begin
        shift_q <= tx_i.data;
        par_bit <= parity_of(tx_i.data, cfg_i.parity);
        par_en  <= (cfg_i.parity != PARITY_NONE);
    end else if ((state == TX_DATA) && baud_done) begin
        shift_q <= shift_q >> 1;
    end
end

assign uart_tx_o = line_q;
assign busy_o    = (state != TX_IDLE) && (state != TX_WAIT);

endmodule
